/* project.f */
+incdir+hw
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/periph_decode.sv
hw/boot_rom.sv
hw/soc_regs.sv
hw/clint_timer.sv
hw/soc_periph_top.sv
test/tb_soc_periph.sv

/* Bender.yml */
package:
  name: soc_periph

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_pkg.sv
      - hw/bus_arbiter.sv
      - hw/periph_decode.sv
      - hw/boot_rom.sv
      - hw/soc_regs.sv
      - hw/clint_timer.sv
      - hw/soc_periph_top.sv
      - target: test
        include_dirs:
          - hw
        files:
          - test/tb_soc_periph.sv

/* test/tb_soc_periph.sv */
// Testbench of the peripheral subsystem
// - clock, reset and watchdog
// - reference model of boot ROM, CSR block and machine timer
// - per-cycle driver with grant and response checks
// - five random tests on both master ports
`timescale 1ns/10ps
`include "soc_params.svh"

module tb_soc_periph import soc_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int N_ROM_RD    = 40;
  localparam int N_ROM_WR    = 8;
  localparam int N_REGS      = 65;
  localparam int N_BOOT_MODE = 4;
  localparam int N_UNMAP     = 30;
  localparam int N_TIMER     = 24;
  localparam int N_MIX_CORE  = 100;
  localparam int N_MIX_DBG   = 80;
  localparam int NUM_TXN     = N_ROM_RD + N_ROM_WR + N_REGS + N_BOOT_MODE + N_UNMAP
                               + N_TIMER + N_MIX_CORE + N_MIX_DBG;
  localparam int DRAIN_LIMIT = 1000;

  localparam addr_t ROM_BASE   = `SOC_BASE_ROM;
  localparam addr_t REGS_BASE  = `SOC_BASE_REGS;
  localparam addr_t CLINT_BASE = `SOC_BASE_CLINT;

  // Expected answer with a flag that enables the data compare
  typedef struct packed {
    logic  chk_data;
    data_t rdata;
    logic  err;
  } exp_rsp_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       rtc;
  logic [1:0] boot_mode;
  bus_req_t   core_req;
  bus_req_t   dbg_req;
  logic       core_gnt;
  logic       dbg_gnt;
  bus_rsp_t   core_rsp;
  bus_rsp_t   dbg_rsp;
  logic       time_irq;
  logic       ipi;

  // Model state
  data_t       scratch [2];
  logic        msip_m;
  logic [63:0] mtime_m;
  logic [63:0] mtimecmp_m;
  arb_prio_e   prio_m;
  bus_req_t    core_q [$];
  bus_req_t    dbg_q [$];
  exp_rsp_t    core_exp [$];
  exp_rsp_t    dbg_exp [$];
  logic        core_due;
  logic        dbg_due;
  logic        rtc_drv;
  logic [1:0]  boot_mode_drv;
  int          seed;
  int unsigned errors;
  int unsigned errors_at_start;
  int unsigned tests_passed;
  int unsigned tests_failed;

  soc_periph_top i_dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .rtc_i       ( rtc       ),
    .boot_mode_i ( boot_mode ),
    .core_req_i  ( core_req  ),
    .dbg_req_i   ( dbg_req   ),
    .core_gnt_o  ( core_gnt  ),
    .dbg_gnt_o   ( dbg_gnt   ),
    .core_rsp_o  ( core_rsp  ),
    .dbg_rsp_o   ( dbg_rsp   ),
    .time_irq_o  ( time_irq  ),
    .ipi_o       ( ipi       )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #((NUM_TXN * 10 + 2000) * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                        input strb_t strb);
    data_t res;
    res = old_val;
    for (int b = 0; b < `SOC_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic bus_req_t make_req(input logic we, input addr_t addr, input data_t wdata,
                                        input strb_t strb);
    bus_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    return r;
  endfunction

  function automatic addr_t rand_offset(input addr_t base, input addr_t mask);
    return base | (addr_t'($random(seed)) & mask);
  endfunction

  // Any region including some unmapped ones above the timer
  function automatic bus_req_t rand_mixed();
    addr_t base;
    logic  we;
    case ($random(seed) & 3)
      0:       base = ROM_BASE;
      1:       base = REGS_BASE;
      2:       base = CLINT_BASE;
      default: base = (addr_t'($random(seed)) & 16'hf000) | 16'h8000;
    endcase
    we = $random(seed) & 1;
    return make_req(we, rand_offset(base, 16'h007c), data_t'($random(seed)),
                    strb_t'($random(seed)));
  endfunction

  task automatic push_req(input logic to_dbg, input bus_req_t r);
    if (to_dbg) begin
      dbg_q.push_back(r);
    end else begin
      core_q.push_back(r);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic model_access(input bus_req_t r, output exp_rsp_t e);
    int unsigned idx;
    idx        = r.addr[`SOC_REGION_LSB-1:2];
    e.chk_data = 1'b1;
    e.err      = 1'b0;
    e.rdata    = '0;
    if (r.addr[15:12] == ROM_BASE[15:12]) begin
      if (r.we) begin
        e.err   = 1'b1;
        e.rdata = `SOC_ERR_DATA;
      end else if (idx < `SOC_ROM_WORDS) begin
        e.rdata = boot_rom_image[idx];
      end
    end else if (r.addr[15:12] == REGS_BASE[15:12]) begin
      if (r.we) begin
        e.chk_data = 1'b0;
        if (idx < 2) begin
          scratch[idx] = merge_bytes(scratch[idx], r.wdata, r.strb);
        end
      end else begin
        case (idx)
          0, 1:    e.rdata = scratch[idx];
          2:       e.rdata = {30'h0, boot_mode};
          3:       e.rdata = `SOC_RTC_FREQ;
          4:       e.rdata = `SOC_HW_FEATURES;
          default: e.rdata = '0;
        endcase
      end
    end else if (r.addr[15:12] == CLINT_BASE[15:12]) begin
      if (r.we) begin
        e.chk_data = 1'b0;
        case (idx)
          0:       msip_m = r.strb[0] ? r.wdata[0] : msip_m;
          1:       mtimecmp_m[31:0]  = merge_bytes(mtimecmp_m[31:0], r.wdata, r.strb);
          2:       mtimecmp_m[63:32] = merge_bytes(mtimecmp_m[63:32], r.wdata, r.strb);
          3:       mtime_m[31:0]     = merge_bytes(mtime_m[31:0], r.wdata, r.strb);
          4:       mtime_m[63:32]    = merge_bytes(mtime_m[63:32], r.wdata, r.strb);
          default: ;
        endcase
      end else begin
        case (idx)
          0:       e.rdata = {31'h0, msip_m};
          1:       e.rdata = mtimecmp_m[31:0];
          2:       e.rdata = mtimecmp_m[63:32];
          3:       e.rdata = mtime_m[31:0];
          4:       e.rdata = mtime_m[63:32];
          default: e.rdata = '0;
        endcase
      end
    end else begin
      e.err   = 1'b1;
      e.rdata = `SOC_ERR_DATA;
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp_bit);
    if (got !== exp_bit) begin
      $display("FAILED %s: got %h expected %h", name, got, exp_bit);
      errors++;
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t got, input logic due,
                           input exp_rsp_t e);
    if (!due) begin
      if (got.rvalid !== 1'b0) begin
        $display("%s: rvalid without a grant in the previous cycle", name);
        errors++;
      end
    end else if (got.rvalid !== 1'b1) begin
      $display("%s: rvalid missing one cycle after the grant", name);
      errors++;
    end else begin
      if (got.err !== e.err) begin
        $display("FAILED %s.err: got %h expected %h", name, got.err, e.err);
        errors++;
      end
      if (e.chk_data && got.rdata !== e.rdata) begin
        $display("FAILED %s.rdata: got %h expected %h", name, got.rdata, e.rdata);
        errors++;
      end
    end
  endtask

  task automatic check_grant(input string name, input logic got, input logic exp_gnt);
    if (exp_gnt && got !== 1'b1) begin
      $display("%s: grant missing for a pending request", name);
      errors++;
    end else if (got !== exp_gnt) begin
      $display("FAILED %s: got %h expected %h", name, got, exp_gnt);
      errors++;
    end
  endtask

  task automatic check_irq();
    check_bit("time_irq_o", time_irq, mtime_m >= mtimecmp_m);
    check_bit("ipi_o", ipi, msip_m);
  endtask

  //////////////////////////////
  // Bus driver
  //////////////////////////////

  // Drive on the falling edge and sample grants and responses at the rising edge
  task automatic bus_cycle();
    bus_req_t cr;
    bus_req_t dr;
    logic     cg;
    logic     dg;
    bus_rsp_t crsp;
    bus_rsp_t drsp;
    exp_rsp_t e;
    logic     exp_cg;
    logic     exp_dg;
    @(negedge clk);
    cr        = (core_q.size() > 0) ? core_q[0] : '0;
    dr        = (dbg_q.size() > 0) ? dbg_q[0] : '0;
    core_req  = cr;
    dbg_req   = dr;
    rtc       = rtc_drv;
    boot_mode = boot_mode_drv;
    @(posedge clk);
    cg   = core_gnt;
    dg   = dbg_gnt;
    crsp = core_rsp;
    drsp = dbg_rsp;
    // Responses belong to the grants of the previous edge
    e = '0;
    if (core_due) begin
      e = core_exp.pop_front();
    end
    check_rsp("core_rsp_o", crsp, core_due, e);
    e = '0;
    if (dbg_due) begin
      e = dbg_exp.pop_front();
    end
    check_rsp("dbg_rsp_o", drsp, dbg_due, e);
    core_due = 1'b0;
    dbg_due  = 1'b0;
    if (cr.req && dr.req) begin
      exp_cg = (prio_m == PRIO_CORE);
      exp_dg = ~exp_cg;
      prio_m = (prio_m == PRIO_CORE) ? PRIO_DBG : PRIO_CORE;
    end else begin
      exp_cg = cr.req;
      exp_dg = dr.req;
    end
    check_grant("core_gnt_o", cg, exp_cg);
    check_grant("dbg_gnt_o", dg, exp_dg);
    if (cg === 1'b1 && cr.req) begin
      cr = core_q.pop_front();
      model_access(cr, e);
      core_exp.push_back(e);
      core_due = 1'b1;
    end
    if (dg === 1'b1 && dr.req) begin
      dr = dbg_q.pop_front();
      model_access(dr, e);
      dbg_exp.push_back(e);
      dbg_due = 1'b1;
    end
  endtask

  task automatic run_queued();
    int guard;
    guard = 0;
    while ((core_q.size() > 0 || dbg_q.size() > 0 || core_due || dbg_due) &&
           guard < DRAIN_LIMIT) begin
      bus_cycle();
      guard++;
    end
    if (guard >= DRAIN_LIMIT) begin
      $display("Queued transactions did not complete within %0d cycles", DRAIN_LIMIT);
      errors++;
      core_q.delete();
      dbg_q.delete();
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      bus_cycle();
    end
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_rom();
    addr_t mask;
    check_bit("core_rsp_o.rvalid", core_rsp.rvalid, 1'b0);
    check_bit("dbg_rsp_o.rvalid", dbg_rsp.rvalid, 1'b0);
    check_irq();
    // Offsets mostly near the image and sometimes anywhere in the region
    for (int i = 0; i < N_ROM_RD; i++) begin
      mask = (i % 8 == 7) ? 16'h0ffc : 16'h007c;
      push_req(1'b0, make_req(1'b0, rand_offset(ROM_BASE, mask), '0, 4'hf));
    end
    run_queued();
    for (int i = 0; i < N_ROM_WR; i++) begin
      push_req(1'b0, make_req(1'b1, rand_offset(ROM_BASE, 16'h0ffc),
                              data_t'($random(seed)), strb_t'($random(seed))));
    end
    run_queued();
    end_test("reset and boot ROM");
  endtask

  task automatic test_regs();
    logic we;
    for (int i = 0; i < N_REGS - 5; i++) begin
      we = $random(seed) & 1;
      push_req(1'b0, make_req(we, rand_offset(REGS_BASE, 16'h001c),
                              data_t'($random(seed)), strb_t'($random(seed))));
    end
    for (int i = 0; i < 5; i++) begin
      push_req(1'b0, make_req(1'b0, REGS_BASE + addr_t'(4 * i), '0, 4'hf));
    end
    run_queued();
    // Sweep the live boot mode through all four values
    for (int m = 0; m < N_BOOT_MODE; m++) begin
      boot_mode_drv = 2'(m);
      push_req(1'b0, make_req(1'b0, REGS_BASE + 16'h0008, '0, 4'hf));
      run_queued();
    end
    end_test("control registers");
  endtask

  task automatic test_unmapped();
    addr_t a;
    logic  we;
    logic  port;
    for (int i = 0; i < N_UNMAP; i++) begin
      a = addr_t'($random(seed));
      if (a[15:12] < 4'h3) begin
        a[15:12] = a[15:12] + 4'h3;
      end
      we   = $random(seed) & 1;
      port = $random(seed) & 1;
      push_req(port, make_req(we, a, data_t'($random(seed)), 4'hf));
    end
    run_queued();
    end_test("unmapped regions");
  endtask

  task automatic test_timer();
    int n;
    rtc_drv = 1'b0;
    push_req(1'b0, make_req(1'b1, CLINT_BASE, 32'h1, 4'hf));
    push_req(1'b0, make_req(1'b0, CLINT_BASE, '0, 4'hf));
    run_queued();
    check_irq();
    push_req(1'b0, make_req(1'b1, CLINT_BASE, 32'h0, 4'hf));
    run_queued();
    check_irq();
    // mtime and mtimecmp both zero
    push_req(1'b0, make_req(1'b1, CLINT_BASE + 16'h0c, 32'h0, 4'hf));
    push_req(1'b0, make_req(1'b1, CLINT_BASE + 16'h10, 32'h0, 4'hf));
    push_req(1'b0, make_req(1'b1, CLINT_BASE + 16'h04, 32'h0, 4'hf));
    push_req(1'b0, make_req(1'b1, CLINT_BASE + 16'h08, 32'h0, 4'hf));
    run_queued();
    check_irq();
    push_req(1'b0, make_req(1'b1, CLINT_BASE + 16'h08, 32'hffff_0000, 4'hf));
    run_queued();
    check_irq();
    n = 3 + ($random(seed) & 7);
    for (int i = 0; i < n; i++) begin
      rtc_drv = 1'b1;
      idle_cycles(4);
      rtc_drv = 1'b0;
      idle_cycles(8);
      mtime_m = mtime_m + 1;
    end
    push_req(1'b0, make_req(1'b0, CLINT_BASE + 16'h0c, '0, 4'hf));
    push_req(1'b0, make_req(1'b0, CLINT_BASE + 16'h10, '0, 4'hf));
    run_queued();
    check_irq();
    end_test("machine timer");
  endtask

  task automatic test_mixed();
    for (int i = 0; i < N_MIX_CORE; i++) begin
      push_req(1'b0, rand_mixed());
    end
    for (int i = 0; i < N_MIX_DBG; i++) begin
      push_req(1'b1, rand_mixed());
    end
    run_queued();
    check_irq();
    end_test("two masters in contention");
  endtask

  initial begin
    seed            = 32'hf3f73e19;
    rst_n           = 1'b0;
    rtc             = 1'b0;
    rtc_drv         = 1'b0;
    core_req        = '0;
    dbg_req         = '0;
    boot_mode       = 2'($random(seed));
    boot_mode_drv   = boot_mode;
    scratch[0]      = '0;
    scratch[1]      = '0;
    msip_m          = 1'b0;
    mtime_m         = `SOC_MTIME_RESET;
    mtimecmp_m      = `SOC_MTIMECMP_RESET;
    prio_m          = PRIO_CORE;
    core_due        = 1'b0;
    dbg_due         = 1'b0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_rom();
    test_regs();
    test_unmapped();
    test_timer();
    test_mixed();
    $display("tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* hw/soc_periph_top.sv */
// Peripheral subsystem top level
// Two masters share one register bus through the arbiter, the
// decoder routes it to boot ROM, CSR block and machine timer
`timescale 1ns/10ps

module soc_periph_top import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rtc_i,
  input  logic [1:0] boot_mode_i,
  input  bus_req_t   core_req_i,
  input  bus_req_t   dbg_req_i,
  output logic       core_gnt_o,
  output logic       dbg_gnt_o,
  output bus_rsp_t   core_rsp_o,
  output bus_rsp_t   dbg_rsp_o,
  output logic       time_irq_o,
  output logic       ipi_o
);

  // Shared bus after arbitration
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  // Per-slave channels
  bus_req_t rom_req,   regs_req,   clint_req;
  bus_rsp_t rom_rsp,   regs_rsp,   clint_rsp;

  //////////////////////////////
  // Interconnect
  //////////////////////////////

  bus_arbiter i_bus_arbiter (
    .clk_i,
    .rst_n_i,
    .core_req_i,
    .dbg_req_i,
    .core_gnt_o,
    .dbg_gnt_o,
    .bus_req_o  ( bus_req ),
    .bus_rsp_i  ( bus_rsp ),
    .core_rsp_o,
    .dbg_rsp_o
  );

  periph_decode i_periph_decode (
    .clk_i,
    .rst_n_i,
    .bus_req_i   ( bus_req   ),
    .bus_rsp_o   ( bus_rsp   ),
    .rom_req_o   ( rom_req   ),
    .regs_req_o  ( regs_req  ),
    .clint_req_o ( clint_req ),
    .rom_rsp_i   ( rom_rsp   ),
    .regs_rsp_i  ( regs_rsp  ),
    .clint_rsp_i ( clint_rsp )
  );

  //////////////////////////////
  // Slaves
  //////////////////////////////

  boot_rom i_boot_rom (
    .clk_i,
    .rst_n_i,
    .bus_req_i ( rom_req ),
    .bus_rsp_o ( rom_rsp )
  );

  soc_regs i_soc_regs (
    .clk_i,
    .rst_n_i,
    .boot_mode_i,
    .bus_req_i ( regs_req ),
    .bus_rsp_o ( regs_rsp )
  );

  clint_timer i_clint_timer (
    .clk_i,
    .rst_n_i,
    .rtc_i,
    .bus_req_i  ( clint_req ),
    .bus_rsp_o  ( clint_rsp ),
    .time_irq_o,
    .ipi_o
  );

endmodule

/* hw/clint_timer.sv */
// Machine timer in the style of a CLINT
// - mtime counts rising edges of the synchronized RTC input
// - mtimecmp raises the timer interrupt, msip the software interrupt
`timescale 1ns/10ps
`include "soc_params.svh"

module clint_timer import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     rtc_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     time_irq_o,
  output logic     ipi_o
);

  localparam int unsigned WORD_W = `SOC_REGION_LSB - 2;
  localparam int unsigned DW     = `SOC_DATA_WIDTH;
  localparam int unsigned TW     = `SOC_TIMER_WIDTH;

  localparam logic [WORD_W-1:0] IDX_MSIP     = WORD_W'(0);
  localparam logic [WORD_W-1:0] IDX_CMP_LO   = WORD_W'(1);
  localparam logic [WORD_W-1:0] IDX_CMP_HI   = WORD_W'(2);
  localparam logic [WORD_W-1:0] IDX_MTIME_LO = WORD_W'(3);
  localparam logic [WORD_W-1:0] IDX_MTIME_HI = WORD_W'(4);

  logic [2:0]        rtc_sync_q;
  logic              rtc_tick;
  logic [WORD_W-1:0] word_idx;
  logic              wr_en;
  data_t             wmask;
  data_t             rd_data;
  logic              msip_q;
  logic              msip_d;
  logic [TW-1:0]     mtime_q;
  logic [TW-1:0]     mtime_d;
  logic [TW-1:0]     mtimecmp_q;
  logic [TW-1:0]     mtimecmp_d;
  logic              rvalid_q;
  data_t             rdata_q;

  //////////////////////////////
  // RTC edge detection
  //////////////////////////////

  // Two synchronizer flops, the third one delays for edge detection
  assign rtc_tick = rtc_sync_q[1] & ~rtc_sync_q[2];

  //////////////////////////////
  // Register access
  //////////////////////////////

  assign word_idx = bus_req_i.addr[`SOC_REGION_LSB-1:2];
  assign wr_en    = bus_req_i.req & bus_req_i.we;

  always_comb begin
    for (int i = 0; i < `SOC_STRB_WIDTH; i++) begin
      wmask[8*i +: 8] = {8{bus_req_i.strb[i]}};
    end
  end

  // A bus write to an mtime half wins over a tick in the same cycle
  always_comb begin
    msip_d     = msip_q;
    mtimecmp_d = mtimecmp_q;
    mtime_d    = rtc_tick ? mtime_q + 1'b1 : mtime_q;
    if (wr_en) begin
      case (word_idx)
        IDX_MSIP: begin
          if (bus_req_i.strb[0]) begin
            msip_d = bus_req_i.wdata[0];
          end
        end
        IDX_CMP_LO: mtimecmp_d[DW-1:0] = (mtimecmp_q[DW-1:0] & ~wmask) | (bus_req_i.wdata & wmask);
        IDX_CMP_HI: mtimecmp_d[TW-1:DW] = (mtimecmp_q[TW-1:DW] & ~wmask) | (bus_req_i.wdata & wmask);
        IDX_MTIME_LO: mtime_d[DW-1:0] = (mtime_q[DW-1:0] & ~wmask) | (bus_req_i.wdata & wmask);
        IDX_MTIME_HI: mtime_d[TW-1:DW] = (mtime_q[TW-1:DW] & ~wmask) | (bus_req_i.wdata & wmask);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (word_idx)
      IDX_MSIP:     rd_data = data_t'(msip_q);
      IDX_CMP_LO:   rd_data = mtimecmp_q[DW-1:0];
      IDX_CMP_HI:   rd_data = mtimecmp_q[TW-1:DW];
      IDX_MTIME_LO: rd_data = mtime_q[DW-1:0];
      IDX_MTIME_HI: rd_data = mtime_q[TW-1:DW];
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rtc_sync_q <= '0;
      msip_q     <= 1'b0;
      mtime_q    <= `SOC_MTIME_RESET;
      mtimecmp_q <= `SOC_MTIMECMP_RESET;
      rvalid_q   <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      msip_q     <= msip_d;
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_q   <= bus_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rd_data;
    end
  end

  assign bus_rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  // Interrupt outputs
  assign time_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o      = msip_q;

endmodule

/* hw/soc_regs.sv */
// Control and status registers
// Two scratch words, live boot mode, RTC frequency and feature bits
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_regs import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [1:0] boot_mode_i,
  input  bus_req_t   bus_req_i,
  output bus_rsp_t   bus_rsp_o
);

  localparam int unsigned WORD_W = `SOC_REGION_LSB - 2;

  localparam logic [WORD_W-1:0] IDX_SCRATCH0 = WORD_W'(0);
  localparam logic [WORD_W-1:0] IDX_SCRATCH1 = WORD_W'(1);
  localparam logic [WORD_W-1:0] IDX_BOOTMODE = WORD_W'(2);
  localparam logic [WORD_W-1:0] IDX_RTCFREQ  = WORD_W'(3);
  localparam logic [WORD_W-1:0] IDX_FEATURES = WORD_W'(4);

  logic [WORD_W-1:0] word_idx;
  logic              wr_en;
  data_t             wmask;
  data_t             rd_data;
  data_t             scratch0_q;
  data_t             scratch1_q;
  logic              rvalid_q;
  data_t             rdata_q;

  assign word_idx = bus_req_i.addr[`SOC_REGION_LSB-1:2];
  assign wr_en    = bus_req_i.req & bus_req_i.we;

  // Expand byte strobes to a bit mask
  always_comb begin
    for (int i = 0; i < `SOC_STRB_WIDTH; i++) begin
      wmask[8*i +: 8] = {8{bus_req_i.strb[i]}};
    end
  end

  always_comb begin
    case (word_idx)
      IDX_SCRATCH0: rd_data = scratch0_q;
      IDX_SCRATCH1: rd_data = scratch1_q;
      IDX_BOOTMODE: rd_data = data_t'(boot_mode_i);
      IDX_RTCFREQ:  rd_data = `SOC_RTC_FREQ;
      IDX_FEATURES: rd_data = `SOC_HW_FEATURES;
      default:      rd_data = '0;
    endcase
  end

  // Only the scratch words are writable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scratch0_q <= '0;
      scratch1_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (wr_en && word_idx == IDX_SCRATCH0) begin
        scratch0_q <= (scratch0_q & ~wmask) | (bus_req_i.wdata & wmask);
      end
      if (wr_en && word_idx == IDX_SCRATCH1) begin
        scratch1_q <= (scratch1_q & ~wmask) | (bus_req_i.wdata & wmask);
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rd_data;
    end
  end

  assign bus_rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

endmodule

/* hw/boot_rom.sv */
// Boot ROM slave
// Reads the boot image with one cycle of latency, writes are errors
`timescale 1ns/10ps
`include "soc_params.svh"

module boot_rom import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  localparam int unsigned IDX_W = $clog2(`SOC_ROM_WORDS);

  logic [IDX_W-1:0] word_idx;
  logic             in_image;
  logic             rvalid_q;
  logic             err_q;
  data_t            rdata_q;

  assign word_idx = bus_req_i.addr[IDX_W+1:2];
  // Offsets past the image read as zero
  assign in_image = (bus_req_i.addr[`SOC_REGION_LSB-1:IDX_W+2] == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      err_q    <= bus_req_i.req & bus_req_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      if (bus_req_i.we) begin
        rdata_q <= `SOC_ERR_DATA;
      end else if (in_image) begin
        rdata_q <= boot_rom_image[word_idx];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus_rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: err_q};

endmodule

/* hw/periph_decode.sv */
// Address decoder of the peripheral bus
// Routes each request to boot ROM, register block or timer,
// answers unmapped regions itself and muxes the responses
`timescale 1ns/10ps
`include "soc_params.svh"

module periph_decode import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output bus_req_t rom_req_o,
  output bus_req_t regs_req_o,
  output bus_req_t clint_req_o,
  input  bus_rsp_t rom_rsp_i,
  input  bus_rsp_t regs_rsp_i,
  input  bus_rsp_t clint_rsp_i
);

  localparam int unsigned TGT_ROM   = 0;
  localparam int unsigned TGT_REGS  = 1;
  localparam int unsigned TGT_CLINT = 2;
  localparam int unsigned TGT_ERR   = 3;
  localparam int unsigned NUM_TGT   = 4;

  localparam addr_t BASE_ROM   = `SOC_BASE_ROM;
  localparam addr_t BASE_REGS  = `SOC_BASE_REGS;
  localparam addr_t BASE_CLINT = `SOC_BASE_CLINT;

  logic [`SOC_ADDR_WIDTH-1:`SOC_REGION_LSB] region;
  logic [NUM_TGT-1:0] sel_d;
  logic [NUM_TGT-1:0] sel_q;

  assign region = bus_req_i.addr[`SOC_ADDR_WIDTH-1:`SOC_REGION_LSB];

  // One-hot target, anything unmapped lands on the error slave
  always_comb begin
    sel_d = '0;
    if (region == BASE_ROM[`SOC_ADDR_WIDTH-1:`SOC_REGION_LSB]) begin
      sel_d[TGT_ROM] = 1'b1;
    end else if (region == BASE_REGS[`SOC_ADDR_WIDTH-1:`SOC_REGION_LSB]) begin
      sel_d[TGT_REGS] = 1'b1;
    end else if (region == BASE_CLINT[`SOC_ADDR_WIDTH-1:`SOC_REGION_LSB]) begin
      sel_d[TGT_CLINT] = 1'b1;
    end else begin
      sel_d[TGT_ERR] = 1'b1;
    end
  end

  always_comb begin
    rom_req_o       = bus_req_i;
    rom_req_o.req   = bus_req_i.req & sel_d[TGT_ROM];
    regs_req_o      = bus_req_i;
    regs_req_o.req  = bus_req_i.req & sel_d[TGT_REGS];
    clint_req_o     = bus_req_i;
    clint_req_o.req = bus_req_i.req & sel_d[TGT_CLINT];
  end

  // Remember the target for the response one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else begin
      sel_q <= bus_req_i.req ? sel_d : '0;
    end
  end

  always_comb begin
    bus_rsp_o = '0;
    if (sel_q[TGT_ROM]) begin
      bus_rsp_o = rom_rsp_i;
    end else if (sel_q[TGT_REGS]) begin
      bus_rsp_o = regs_rsp_i;
    end else if (sel_q[TGT_CLINT]) begin
      bus_rsp_o = clint_rsp_i;
    end else if (sel_q[TGT_ERR]) begin
      bus_rsp_o.rvalid = 1'b1;
      bus_rsp_o.rdata  = `SOC_ERR_DATA;
      bus_rsp_o.err    = 1'b1;
    end
  end

endmodule

/* hw/bus_arbiter.sv */
// Round-robin arbiter for two register bus masters
// Grants core or debug port, forwards the winner's request and
// steers the response back to the master granted a cycle earlier
`timescale 1ns/10ps

module bus_arbiter import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t core_req_i,
  input  bus_req_t dbg_req_i,
  output logic     core_gnt_o,
  output logic     dbg_gnt_o,
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i,
  output bus_rsp_t core_rsp_o,
  output bus_rsp_t dbg_rsp_o
);

  arb_prio_e prio_q;
  arb_prio_e prio_d;
  logic      contention;
  logic      owner_core_q;
  logic      owner_dbg_q;

  //////////////////////////////
  // Grant
  //////////////////////////////

  assign contention = core_req_i.req & dbg_req_i.req;

  // Lone requester wins at once, otherwise the priority state decides
  assign core_gnt_o = core_req_i.req & (~dbg_req_i.req | (prio_q == PRIO_CORE));
  assign dbg_gnt_o  = dbg_req_i.req & (~core_req_i.req | (prio_q == PRIO_DBG));

  // With no grant the core request carries req low
  assign bus_req_o = dbg_gnt_o ? dbg_req_i : core_req_i;

  // Flip priority only when both masters fought for the bus
  always_comb begin
    prio_d = prio_q;
    if (contention) begin
      prio_d = (prio_q == PRIO_CORE) ? PRIO_DBG : PRIO_CORE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q       <= PRIO_CORE;
      owner_core_q <= 1'b0;
      owner_dbg_q  <= 1'b0;
    end else begin
      prio_q       <= prio_d;
      owner_core_q <= core_gnt_o;
      owner_dbg_q  <= dbg_gnt_o;
    end
  end

  //////////////////////////////
  // Response steering
  //////////////////////////////

  always_comb begin
    core_rsp_o        = bus_rsp_i;
    core_rsp_o.rvalid = bus_rsp_i.rvalid & owner_core_q;
    dbg_rsp_o         = bus_rsp_i;
    dbg_rsp_o.rvalid  = bus_rsp_i.rvalid & owner_dbg_q;
  end

endmodule

/* hw/soc_pkg.sv */
// Shared types of the peripheral subsystem
// - width typedefs for address, data and byte enables
// - request and response structs of the register bus
// - arbiter priority state
// - boot ROM image
`include "soc_params.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`SOC_DATA_WIDTH-1:0] data_t;
  typedef logic [`SOC_STRB_WIDTH-1:0] strb_t;

  // Master to slave, held stable until granted
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  // Slave to master, one cycle after the grant
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Which master wins the next contention
  typedef enum logic {
    PRIO_CORE = 1'b0,
    PRIO_DBG  = 1'b1
  } arb_prio_e;

  // Boot code: find the hart ID, load the entry point and park
  localparam data_t boot_rom_image [`SOC_ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0005_a283,
    32'h0002_8067, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013,
    32'h8000_0000, 32'h0000_0000, 32'h0000_1008, 32'h0000_2000,
    32'h0000_0013, 32'h0000_0013, 32'hc0de_b007, 32'h5a5a_a5a5
  };

endpackage

/* hw/soc_params.svh */
// Global constants of the peripheral subsystem
// Bus widths, region map, error answer and timer reset values
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

//////////////////////////////
// Register bus
//////////////////////////////
`define SOC_ADDR_WIDTH 16
`define SOC_DATA_WIDTH 32
`define SOC_STRB_WIDTH 4

//////////////////////////////
// Address map, 4 KiB regions
//////////////////////////////
`define SOC_REGION_LSB 12
`define SOC_BASE_ROM   16'h0000
`define SOC_BASE_REGS  16'h1000
`define SOC_BASE_CLINT 16'h2000

// Boot image size in words
`define SOC_ROM_WORDS 16

// Read data of the error slave
`define SOC_ERR_DATA 32'hBADCAB1E

// Platform information
`define SOC_RTC_FREQ    32'd32768
`define SOC_HW_FEATURES 32'h0000_0003

// Machine timer
`define SOC_TIMER_WIDTH    64
`define SOC_MTIME_RESET    64'h0
`define SOC_MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif
